//--- Bender.yml
package:
  name: rd_slave

sources:
  - axi_pkg.sv
  - rd_slv_pkg.sv
  - ar_queue.sv
  - fetch_timer.sv
  - rd_burst_fsm.sv
  - burst_addr_gen.sv
  - r_channel_out.sv
  - rd_slave_top.sv
  - target: test
    files:
      - rd_slave_checker.sv
      - tb_rd_slave.sv

//--- ar_queue.sv
`default_nettype none

module ar_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 arvalid,
    output logic                 arready,
    input  axi_pkg::id_t         arid,
    input  axi_pkg::addr_t       araddr,
    input  axi_pkg::len_t        arlen,
    input  axi_pkg::size_t       arsize,
    input  axi_pkg::burst_t      arburst,
    input  logic                 pop,
    output logic                 not_empty,
    output axi_pkg::id_t         head_id,
    output axi_pkg::addr_t       head_addr,
    output axi_pkg::len_t        head_len,
    output axi_pkg::size_t       head_size,
    output axi_pkg::burst_t      head_burst
);
    import axi_pkg::*;
    import rd_slv_pkg::*;

    id_t    id_mem    [OST_DEPTH];
    addr_t  addr_mem  [OST_DEPTH];
    len_t   len_mem   [OST_DEPTH];
    size_t  size_mem  [OST_DEPTH];
    burst_t burst_mem [OST_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;

    assign arready   = (count != cnt_t'(OST_DEPTH));
    assign not_empty = (count != '0);
    assign push      = arvalid & arready;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            if (push && !pop) begin
                count <= count + cnt_t'(1);
            end else if (pop && !push) begin
                count <= count - cnt_t'(1);
            end
        end
    end

    // Request storage
    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr]    <= arid;
            addr_mem[wr_ptr]  <= araddr;
            len_mem[wr_ptr]   <= arlen;
            size_mem[wr_ptr]  <= arsize;
            burst_mem[wr_ptr] <= arburst;
        end
    end

    assign head_id    = id_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_len   = len_mem[rd_ptr];
    assign head_size  = size_mem[rd_ptr];
    assign head_burst = burst_mem[rd_ptr];

endmodule

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

    // Field widths of the read channels
    localparam int ID_W    = 4;
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    typedef logic [ID_W-1:0]    id_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [SIZE_W-1:0]  size_t;
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [RESP_W-1:0]  resp_t;

    // Burst and response encodings
    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;
    localparam burst_t BURST_WRAP  = 2'd2;
    localparam resp_t  RESP_OKAY   = 2'd0;
    localparam resp_t  RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

//--- burst_addr_gen.sv
`default_nettype none

module burst_addr_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_burst,
    input  logic              next_beat,
    input  axi_pkg::addr_t    head_addr,
    input  axi_pkg::len_t     head_len,
    input  axi_pkg::size_t    head_size,
    input  axi_pkg::burst_t   head_burst,
    output axi_pkg::addr_t    cur_addr,
    output rd_slv_pkg::beat_t beat_idx,
    output logic              is_last
);
    import axi_pkg::*;
    import rd_slv_pkg::*;

    // Captured burst fields
    addr_t  start_q;
    len_t   len_q;
    size_t  size_q;
    burst_t burst_q;

    beat_t next_idx;
    addr_t step;
    addr_t bytes_m1;
    addr_t win_m1;
    addr_t wrap_base;
    addr_t next_addr;

    assign next_idx  = beat_idx + beat_t'(1);
    assign step      = addr_t'(next_idx) << size_q;
    assign bytes_m1  = (addr_t'(1) << size_q) - addr_t'(1);
    // Window is beats times bytes per beat, a power of two for legal WRAP
    assign win_m1    = ((addr_t'(len_q) + addr_t'(1)) << size_q) - addr_t'(1);
    assign wrap_base = start_q & ~win_m1;

    always_comb begin
        case (burst_q)
            BURST_INCR: next_addr = (start_q & ~bytes_m1) + step;
            BURST_WRAP: next_addr = wrap_base | (((start_q & win_m1) + step) & win_m1);
            default:    next_addr = start_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (load_burst) begin
            beat_idx <= '0;
        end else if (next_beat) begin
            beat_idx <= next_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (load_burst) begin
            start_q  <= head_addr;
            len_q    <= head_len;
            size_q   <= head_size;
            burst_q  <= head_burst;
            cur_addr <= head_addr;
        end else if (next_beat) begin
            cur_addr <= next_addr;
        end
    end

    assign is_last = (len_t'(beat_idx) == len_q);

endmodule

`default_nettype wire

//--- fetch_timer.sv
`default_nettype none

module fetch_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,
    output logic timer_done
);
    import rd_slv_pkg::*;

    timer_t count;

    // Zero means idle, the last count of 1 marks the end of the delay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (timer_start) begin
            count <= timer_t'(FETCH_DELAY);
        end else if (count != '0) begin
            count <= count - timer_t'(1);
        end
    end

    assign timer_done = (count == timer_t'(1));

endmodule

`default_nettype wire

//--- r_channel_out.sv
`default_nettype none

module r_channel_out (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            beat_load,
    input  axi_pkg::id_t    head_id,
    input  axi_pkg::addr_t  cur_addr,
    input  logic            is_last,
    input  logic            rready,
    output logic            rvalid,
    output axi_pkg::id_t    rid,
    output axi_pkg::data_t  rdata,
    output axi_pkg::resp_t  rresp,
    output logic            rlast,
    output logic            beat_taken
);
    import axi_pkg::*;
    import rd_slv_pkg::*;

    assign beat_taken = rvalid & rready;

    // Valid holds until the master takes the beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end else if (beat_load) begin
            rvalid <= 1'b1;
            rlast  <= is_last;
        end else if (beat_taken) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_load) begin
            rid   <= head_id;
            rdata <= data_t'({head_id, cur_addr});
            rresp <= (head_id == ERR_ID && is_last) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

//--- rd_burst_fsm.sv
`default_nettype none

module rd_burst_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic not_empty,
    input  logic timer_done,
    input  logic beat_taken,
    input  logic is_last,
    output logic load_burst,
    output logic next_beat,
    output logic timer_start,
    output logic beat_load,
    output logic pop
);
    import rd_slv_pkg::*;

    rd_state_e state;
    rd_state_e state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------------------------------------------------------------
    // Next state and per-cycle strobes
    // --------------------------------------------------------------------------
    always_comb begin
        state_nxt   = state;
        load_burst  = 1'b0;
        next_beat   = 1'b0;
        timer_start = 1'b0;
        beat_load   = 1'b0;
        pop         = 1'b0;
        case (state)
            IDLE: begin
                if (not_empty) begin
                    load_burst  = 1'b1;
                    timer_start = 1'b1;
                    state_nxt   = FETCH;
                end
            end
            FETCH: begin
                if (timer_done) begin
                    beat_load = 1'b1;
                    state_nxt = SEND;
                end
            end
            SEND: begin
                // Burst ends only once its last beat is accepted
                if (beat_taken && is_last) begin
                    pop       = 1'b1;
                    state_nxt = IDLE;
                end else if (beat_taken) begin
                    next_beat   = 1'b1;
                    timer_start = 1'b1;
                    state_nxt   = FETCH;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- rd_slave_checker.sv
`default_nettype none

module rd_slave_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            arvalid,
    input  logic            arready,
    input  axi_pkg::len_t   arlen,
    input  logic            rvalid,
    input  logic            rready,
    input  axi_pkg::id_t    rid,
    input  axi_pkg::data_t  rdata,
    input  axi_pkg::resp_t  rresp,
    input  logic            rlast
);
    timeunit 1ns;
    timeprecision 1ps;

    import rd_slv_pkg::*;

    // --------------------------------------------------------------------------
    // AR channel
    // --------------------------------------------------------------------------
    ar_len_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && arready) |-> (arlen <= MAX_BURST_LEN - 1))
        else $error("Accepted request with arlen %0d above the burst limit", arlen);

    // --------------------------------------------------------------------------
    // R channel
    // --------------------------------------------------------------------------
    r_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rid) && $stable(rdata)
                                 && $stable(rresp) && $stable(rlast)))
        else $error("R outputs changed while the beat was stalled");

    // Checked every clock while reset is held
    r_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !rvalid)
        else $error("rvalid high during reset");

endmodule

`default_nettype wire

//--- rd_slave_top.sv
`default_nettype none

module rd_slave_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            arvalid,
    output logic            arready,
    input  axi_pkg::id_t    arid,
    input  axi_pkg::addr_t  araddr,
    input  axi_pkg::len_t   arlen,
    input  axi_pkg::size_t  arsize,
    input  axi_pkg::burst_t arburst,
    output logic            rvalid,
    input  logic            rready,
    output axi_pkg::id_t    rid,
    output axi_pkg::data_t  rdata,
    output axi_pkg::resp_t  rresp,
    output logic            rlast
);
    import axi_pkg::*;

    // --------------------------------------------------------------------------
    // Internal links
    // --------------------------------------------------------------------------
    logic   not_empty;
    logic   pop;
    id_t    head_id;
    addr_t  head_addr;
    len_t   head_len;
    size_t  head_size;
    burst_t head_burst;
    logic   load_burst;
    logic   next_beat;
    logic   timer_start;
    logic   timer_done;
    logic   beat_load;
    logic   beat_taken;
    addr_t  cur_addr;
    logic   is_last;

    ar_queue u_ar_queue (
        .clk(clk), .rst_n(rst_n),
        .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
        .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .pop(pop), .not_empty(not_empty),
        .head_id(head_id), .head_addr(head_addr), .head_len(head_len),
        .head_size(head_size), .head_burst(head_burst)
    );

    fetch_timer u_fetch_timer (
        .clk(clk), .rst_n(rst_n),
        .timer_start(timer_start), .timer_done(timer_done)
    );

    rd_burst_fsm u_rd_burst_fsm (
        .clk(clk), .rst_n(rst_n),
        .not_empty(not_empty), .timer_done(timer_done),
        .beat_taken(beat_taken), .is_last(is_last),
        .load_burst(load_burst), .next_beat(next_beat),
        .timer_start(timer_start), .beat_load(beat_load), .pop(pop)
    );

    burst_addr_gen u_burst_addr_gen (
        .clk(clk), .rst_n(rst_n),
        .load_burst(load_burst), .next_beat(next_beat),
        .head_addr(head_addr), .head_len(head_len),
        .head_size(head_size), .head_burst(head_burst),
        .cur_addr(cur_addr), .beat_idx(), .is_last(is_last)
    );

    r_channel_out u_r_channel_out (
        .clk(clk), .rst_n(rst_n),
        .beat_load(beat_load), .head_id(head_id), .cur_addr(cur_addr),
        .is_last(is_last), .rready(rready), .rvalid(rvalid), .rid(rid),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .beat_taken(beat_taken)
    );

endmodule

`default_nettype wire

//--- rd_slv_pkg.sv
`default_nettype none

package rd_slv_pkg;

    // Outstanding request queue
    localparam int OST_DEPTH = 4;
    localparam int PTR_W     = 2;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    // Burst limits
    localparam int MAX_BURST_LEN = 8;
    typedef logic [$clog2(MAX_BURST_LEN)-1:0] beat_t;

    // Modelled memory latency per beat
    localparam int FETCH_DELAY = 18;
    typedef logic [4:0] timer_t;

    // This ID answers SLVERR on its last beat
    localparam axi_pkg::id_t ERR_ID = 4'hF;

    typedef enum logic [1:0] {IDLE, FETCH, SEND} rd_state_e;

endpackage

`default_nettype wire

//--- tb_rd_slave.sv
`default_nettype none

module tb_rd_slave;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;
    import rd_slv_pkg::*;

    localparam int NUM_ROWS   = 7;
    localparam int AR_TIMEOUT = 1000;
    localparam int R_TIMEOUT  = 200;

    logic   clk;
    logic   rst_n;
    logic   arvalid;
    logic   arready;
    id_t    arid;
    addr_t  araddr;
    len_t   arlen;
    size_t  arsize;
    burst_t arburst;
    logic   rvalid;
    logic   rready;
    id_t    rid;
    data_t  rdata;
    resp_t  rresp;
    logic   rlast;

    // --------------------------------------------------------------------------
    // Request table: id, address, length, size, burst, stall
    // --------------------------------------------------------------------------
    id_t    tbl_id    [NUM_ROWS] = '{4'd1, 4'd2, 4'd3, 4'd15, 4'd4, 4'd6, 4'd15};
    addr_t  tbl_addr  [NUM_ROWS] = '{16'h0106, 16'h0218, 16'h0344, 16'h0400,
                                     16'h0400, 16'h0526, 16'h0600};
    len_t   tbl_len   [NUM_ROWS] = '{8'd7, 8'd3, 8'd3, 8'd3, 8'd3, 8'd7, 8'd2};
    size_t  tbl_size  [NUM_ROWS] = '{3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd1, 3'd0};
    burst_t tbl_burst [NUM_ROWS] = '{BURST_INCR, BURST_WRAP, BURST_FIXED, BURST_INCR,
                                     BURST_INCR, BURST_WRAP, BURST_INCR};
    bit     tbl_stall [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

    // Expected beats in issue order
    id_t   exp_id   [$];
    data_t exp_data [$];
    resp_t exp_resp [$];
    logic  exp_last [$];
    int    exp_row  [$];

    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int accepted     = 0;
    int bursts_done  = 0;
    int seed         = 32'h24ce;
    bit timed_out    = 1'b0;
    bit full_seen    = 1'b0;

    rd_slave_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
        .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
        .rresp(rresp), .rlast(rlast)
    );

    bind rd_slave_top rd_slave_checker chk0 (
        .clk(clk), .rst_n(rst_n), .arvalid(arvalid), .arready(arready),
        .arlen(arlen), .rvalid(rvalid), .rready(rready), .rid(rid),
        .rdata(rdata), .rresp(rresp), .rlast(rlast)
    );

    always #20 clk = ~clk;

    // Address of beat k from the burst rules
    function automatic addr_t beat_addr(addr_t start, len_t len, size_t size,
                                        burst_t burst, int k);
        int a;
        int bytes;
        int win;
        int base;
        a     = int'(start);
        bytes = 1 << size;
        if (k == 0 || burst == BURST_FIXED)
            return start;
        if (burst == BURST_INCR)
            return addr_t'((a / bytes) * bytes + k * bytes);
        win  = (int'(len) + 1) * bytes;
        base = (a / win) * win;
        return addr_t'(base + (a - base + k * bytes) % win);
    endfunction

    task automatic build_expected();
        addr_t a;
        bit    last;
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int k = 0; k <= int'(tbl_len[i]); k++) begin
                a    = beat_addr(tbl_addr[i], tbl_len[i], tbl_size[i], tbl_burst[i], k);
                last = (k == int'(tbl_len[i]));
                exp_id.push_back(tbl_id[i]);
                exp_data.push_back((data_t'(tbl_id[i]) << ADDR_W) | data_t'(a));
                exp_resp.push_back((tbl_id[i] == ERR_ID && last) ? RESP_SLVERR : RESP_OKAY);
                exp_last.push_back(last);
                exp_row.push_back(i);
            end
        end
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp,
                               inout int burst_errs);
        if (got !== exp) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
            burst_errs++;
        end
    endtask

    function automatic logic pick_rready(int row);
        int r;
        r = $random(seed);
        return tbl_stall[row] ? r[0] : 1'b1;
    endfunction

    // --------------------------------------------------------------------------
    // Request issuer
    // --------------------------------------------------------------------------
    task automatic issue_requests();
        int wait_cycles;
        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            arvalid     = 1'b1;
            arid        = tbl_id[i];
            araddr      = tbl_addr[i];
            arlen       = tbl_len[i];
            arsize      = tbl_size[i];
            arburst     = tbl_burst[i];
            wait_cycles = 0;
            while (!arready && wait_cycles < AR_TIMEOUT) begin
                if (!full_seen) begin
                    full_seen = 1'b1;
                    if (accepted == OST_DEPTH && bursts_done == 0) begin
                        tests_passed++;
                        $display("Test queue full: arready low after %0d requests, PASS",
                                 accepted);
                    end else begin
                        tests_failed++;
                        errors++;
                        $display("Test queue full: arready low after %0d requests, %0d done, FAIL",
                                 accepted, bursts_done);
                    end
                end
                @(posedge clk);
                #2;
                wait_cycles++;
            end
            if (!arready) begin
                $display("Request %0d was never accepted, arready stayed low", i);
                errors++;
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                accepted++;
            end
        end
        arvalid = 1'b0;
    endtask

    // --------------------------------------------------------------------------
    // Response collector
    // --------------------------------------------------------------------------
    task automatic collect_beats();
        int wait_cycles;
        int row;
        int burst_errs;
        burst_errs = 0;
        while (exp_data.size() > 0 && !timed_out) begin
            row         = exp_row[0];
            wait_cycles = 0;
            rready      = pick_rready(row);
            while (!(rvalid && rready) && wait_cycles < R_TIMEOUT) begin
                @(posedge clk);
                #2;
                rready = pick_rready(row);
                wait_cycles++;
            end
            if (!(rvalid && rready)) begin
                $display("No beat arrived for burst %0d before the timeout", row);
                errors++;
                timed_out = 1'b1;
            end else begin
                check_field("rid", 32'(rid), 32'(exp_id[0]), burst_errs);
                check_field("rdata", rdata, exp_data[0], burst_errs);
                check_field("rresp", 32'(rresp), 32'(exp_resp[0]), burst_errs);
                check_field("rlast", 32'(rlast), 32'(exp_last[0]), burst_errs);
                if (exp_last[0]) begin
                    bursts_done++;
                    if (burst_errs == 0)
                        tests_passed++;
                    else
                        tests_failed++;
                    $display("Test burst %0d id %0d: %0d beats, %0d errors, %s", row,
                             tbl_id[row], tbl_len[row] + 1, burst_errs,
                             (burst_errs == 0) ? "PASS" : "FAIL");
                    burst_errs = 0;
                end
                void'(exp_id.pop_front());
                void'(exp_data.pop_front());
                void'(exp_resp.pop_front());
                void'(exp_last.pop_front());
                void'(exp_row.pop_front());
                @(posedge clk);
                #2;
            end
        end
        rready = 1'b0;
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = '0;
        rready  = 1'b0;
        build_expected();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            issue_requests();
            collect_beats();
        join
        if (!full_seen) begin
            $display("Test queue full: arready never dropped, FAIL");
            tests_failed++;
            errors++;
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
axi_pkg.sv
rd_slv_pkg.sv
ar_queue.sv
fetch_timer.sv
rd_burst_fsm.sv
burst_addr_gen.sv
r_channel_out.sv
rd_slave_top.sv
rd_slave_checker.sv
tb_rd_slave.sv
